// File: ldmr_top.f
source/ldmr_pkg.sv
source/ldmr_cmd_if.sv
source/ldmr_beat_if.sv
source/ldmr_regfile.sv
source/ldmr_cmd_fifo.sv
source/ldmr_read_ctrl.sv
source/ldmr_bank_writer.sv
source/ldmr_top.sv
verif/ldmr_tb.sv

// File: source/ldmr_bank_writer.sv
`timescale 1ns/1ps

module ldmr_bank_writer import ldmr_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    ldmr_beat_if.dst              beat,
    output logic                  hpu_core_sel_o,
    output logic [NUM_BANKS-1:0]  mtx_sel_o,
    output logic [DDR_DATA_W-1:0] mtx_wdata_o,
    output logic [MRA_IDX_W-1:0]  mra_windex_o,
    output logic [MTX_ADDR_W-1:0] mra_waddr_o,
    output logic                  mra_we_o,
    output logic [MRB_IDX_W-1:0]  mrb_windex_o,
    output logic [MTX_ADDR_W-1:0] mrb_waddr_o,
    output logic                  mrb_we_o,
    output logic [MRC_IDX_W-1:0]  mrc_windex_o,
    output logic [MTX_ADDR_W-1:0] mrc_waddr_o,
    output logic                  mrc_we_o,
    output logic [BR_IDX_W-1:0]   brb_windex_o,
    output logic [MTX_ADDR_W-1:0] brb_waddr_o,
    output logic                  brb_we_o,
    output logic [BR_IDX_W-1:0]   brc_windex_o,
    output logic [MTX_ADDR_W-1:0] brc_waddr_o,
    output logic                  brc_we_o
);

    logic [DDR_LEN_W-1:0]  run_addr;
    logic [MTX_IDX_W-1:0]  idx_next;
    logic [NUM_BANKS-1:0]  sel_next;
    logic [NUM_BANKS-1:0]  sel_q;
    logic                  we_q;
    logic                  core_q;
    logic [MTX_IDX_W-1:0]  idx_q;
    logic [MTX_ADDR_W-1:0] addr_q;
    logic [DDR_DATA_W-1:0] data_q;
    logic [MTX_IDX_W-1:0]  mra_rel;
    logic [MTX_IDX_W-1:0]  mrb_rel;
    logic [MTX_IDX_W-1:0]  mrc_rel;
    logic [MTX_IDX_W-1:0]  brb_rel;
    logic [MTX_IDX_W-1:0]  brc_rel;

    // overflow past 512 rolls into the next register
    assign run_addr = {{(DDR_LEN_W-MTX_ADDR_W){1'b0}}, beat.waddr_base} + beat.beat_cnt;
    assign idx_next = beat.mtx_index + run_addr[MTX_IDX_W+MTX_ADDR_W-1:MTX_ADDR_W];

    // one-hot bank select by index range
    always_comb begin
        if (idx_next < MRB_BASE) begin
            sel_next = 5'b00001;
        end else if (idx_next < MRC_BASE) begin
            sel_next = 5'b00010;
        end else if (idx_next < BRB_BASE) begin
            sel_next = 5'b00100;
        end else if (idx_next == BRB_BASE) begin
            sel_next = 5'b01000;
        end else if (idx_next == BRC_BASE) begin
            sel_next = 5'b10000;
        end else begin
            sel_next = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sel_q  <= '0;
            we_q   <= 1'b0;
            core_q <= 1'b0;
            idx_q  <= '0;
            addr_q <= '0;
        end else begin
            we_q <= beat.beat;
            if (beat.beat) begin
                sel_q  <= sel_next;
                core_q <= beat.core_sel;
                idx_q  <= idx_next;
                addr_q <= run_addr[MTX_ADDR_W-1:0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (beat.beat) begin
            data_q <= beat.data;
        end
    end

    // ==================================================
    // per-bank fan-out with zeros when not selected
    // ==================================================
    assign mra_rel = idx_q - MRA_BASE;
    assign mrb_rel = idx_q - MRB_BASE;
    assign mrc_rel = idx_q - MRC_BASE;
    assign brb_rel = idx_q - BRB_BASE;
    assign brc_rel = idx_q - BRC_BASE;

    assign hpu_core_sel_o = core_q;
    assign mtx_sel_o      = sel_q;
    assign mtx_wdata_o    = data_q;

    assign mra_windex_o = sel_q[0] ? mra_rel[MRA_IDX_W-1:0] : '0;
    assign mra_waddr_o  = sel_q[0] ? addr_q : '0;
    assign mra_we_o     = sel_q[0] && we_q;

    assign mrb_windex_o = sel_q[1] ? mrb_rel[MRB_IDX_W-1:0] : '0;
    assign mrb_waddr_o  = sel_q[1] ? addr_q : '0;
    assign mrb_we_o     = sel_q[1] && we_q;

    assign mrc_windex_o = sel_q[2] ? mrc_rel[MRC_IDX_W-1:0] : '0;
    assign mrc_waddr_o  = sel_q[2] ? addr_q : '0;
    assign mrc_we_o     = sel_q[2] && we_q;

    assign brb_windex_o = sel_q[3] ? brb_rel[BR_IDX_W-1:0] : '0;
    assign brb_waddr_o  = sel_q[3] ? addr_q : '0;
    assign brb_we_o     = sel_q[3] && we_q;

    assign brc_windex_o = sel_q[4] ? brc_rel[BR_IDX_W-1:0] : '0;
    assign brc_waddr_o  = sel_q[4] ? addr_q : '0;
    assign brc_we_o     = sel_q[4] && we_q;

endmodule

// File: source/ldmr_beat_if.sv
`timescale 1ns/1ps

interface ldmr_beat_if import ldmr_pkg::*; ();

    // one strobe per accepted ddr beat
    logic                  beat;
    logic                  core_sel;
    logic [MTX_IDX_W-1:0]  mtx_index;
    logic [MTX_ADDR_W-1:0] waddr_base;
    logic [DDR_LEN_W-1:0]  beat_cnt;
    logic [DDR_DATA_W-1:0] data;

    modport src (output beat, core_sel, mtx_index, waddr_base, beat_cnt, data);
    modport dst (input beat, core_sel, mtx_index, waddr_base, beat_cnt, data);

endinterface

// File: source/ldmr_cmd_fifo.sv
`timescale 1ns/1ps

module ldmr_cmd_fifo import ldmr_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_i,
    ldmr_cmd_if.fifo_in  wr,
    ldmr_cmd_if.fifo_out rd
);

    logic [CMD_W-1:0]     mem [CMD_DEPTH];
    logic [CMD_PTR_W-1:0] wr_ptr;
    logic [CMD_PTR_W-1:0] rd_ptr;
    logic [CMD_PTR_W:0]   count;
    logic                 full;
    logic                 do_push;
    logic                 do_pop;

    assign full    = (count == CMD_DEPTH[CMD_PTR_W:0]);
    // pushes to a full queue are dropped
    assign do_push = wr.vld && !full;
    assign do_pop  = rd.pop;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= {wr.core_sel, wr.mtx_index, wr.mtx_offset,
                            wr.src_addr, wr.trans_len};
        end
    end

    // pointers and fill level
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // head shown combinationally
    assign rd.vld = (count != '0);
    assign {rd.core_sel, rd.mtx_index, rd.mtx_offset, rd.src_addr, rd.trans_len} = mem[rd_ptr];

endmodule

// File: source/ldmr_cmd_if.sv
`timescale 1ns/1ps

interface ldmr_cmd_if import ldmr_pkg::*; ();

    logic                  vld;
    logic                  pop;
    logic                  core_sel;
    logic [MTX_IDX_W-1:0]  mtx_index;
    logic [MTX_ADDR_W-1:0] mtx_offset;
    logic [DDR_ADDR_W-1:0] src_addr;
    logic [DDR_LEN_W-1:0]  trans_len;

    // register file side, single-cycle push strobe
    modport push (output vld, core_sel, mtx_index, mtx_offset, src_addr, trans_len);
    modport fifo_in (input vld, core_sel, mtx_index, mtx_offset, src_addr, trans_len);

    // queue head, vld means not empty
    modport fifo_out (output vld, core_sel, mtx_index, mtx_offset, src_addr, trans_len,
                      input pop);
    modport take (input vld, core_sel, mtx_index, mtx_offset, src_addr, trans_len,
                  output pop);

endinterface

// File: source/ldmr_pkg.sv
package ldmr_pkg;

    // ==================================================
    // bus widths
    // ==================================================
    localparam int REG_ADDR_W = 8;
    localparam int REG_DATA_W = 32;
    localparam int REG_WORD_W = REG_ADDR_W - 2;
    localparam int DDR_ADDR_W = 26;
    localparam int DDR_LEN_W  = 16;
    localparam int DDR_DATA_W = 512;
    localparam int MTX_IDX_W  = 5;
    localparam int MTX_ADDR_W = 9;
    localparam int NUM_BANKS  = 5;

    // command queue
    localparam int CMD_DEPTH = 16;
    localparam int CMD_PTR_W = $clog2(CMD_DEPTH);
    localparam int CMD_W     = 1 + MTX_IDX_W + MTX_ADDR_W + DDR_ADDR_W + DDR_LEN_W;

    // ==================================================
    // register word addresses (byte address / 4)
    // ==================================================
    localparam logic [REG_WORD_W-1:0] ADDR_CTRL = 6'd0;
    localparam logic [REG_WORD_W-1:0] ADDR_SRC  = 6'd1;
    localparam logic [REG_WORD_W-1:0] ADDR_LEN  = 6'd2;
    localparam logic [REG_WORD_W-1:0] ADDR_CORE = 6'd3;
    localparam logic [REG_WORD_W-1:0] ADDR_DEST = 6'd4;

    // ==================================================
    // global matrix index layout
    // ==================================================
    localparam logic [MTX_IDX_W-1:0] MRA_BASE = 5'd0;
    localparam logic [MTX_IDX_W-1:0] MRB_BASE = 5'd8;
    localparam logic [MTX_IDX_W-1:0] MRC_BASE = 5'd16;
    localparam logic [MTX_IDX_W-1:0] BRB_BASE = 5'd18;
    localparam logic [MTX_IDX_W-1:0] BRC_BASE = 5'd19;

    localparam int MRA_IDX_W = 3;
    localparam int MRB_IDX_W = 3;
    localparam int MRC_IDX_W = 1;
    localparam int BR_IDX_W  = 1;

    // destination register, laid out per core
    typedef struct packed {
        logic [17:0]           rsvd;
        logic [MTX_IDX_W-1:0]  index;
        logic [MTX_ADDR_W-1:0] offset;
    } dest_core0_t;

    typedef struct packed {
        logic [1:0]            rsvd_hi;
        logic [MTX_IDX_W-1:0]  index;
        logic [MTX_ADDR_W-1:0] offset;
        logic [15:0]           rsvd_lo;
    } dest_core1_t;

    typedef union packed {
        dest_core0_t core0;
        dest_core1_t core1;
    } dest_addr_u;

endpackage

// File: source/ldmr_read_ctrl.sv
`timescale 1ns/1ps

module ldmr_read_ctrl import ldmr_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  intr_clr_i,
    input  logic                  ddr_rcmd_rdy_i,
    input  logic                  ddr_rdata_vld_i,
    input  logic                  ddr_rdata_last_i,
    input  logic [DDR_DATA_W-1:0] ddr_rdata_i,
    output logic [DDR_ADDR_W-1:0] ddr_raddr_o,
    output logic [DDR_LEN_W-1:0]  ddr_rlen_o,
    output logic                  ddr_rcmd_vld_o,
    output logic                  ddr_rdata_rdy_o,
    output logic                  intr_o,
    ldmr_cmd_if.take              cmd,
    ldmr_beat_if.src              beat
);

    logic                  busy_q;
    logic                  intr_q;
    logic                  core_q;
    logic [MTX_IDX_W-1:0]  idx_q;
    logic [MTX_ADDR_W-1:0] base_q;
    logic [DDR_LEN_W-1:0]  len_m1_q;
    logic [DDR_LEN_W-1:0]  beat_cnt_q;
    logic                  issue;
    logic                  accept;
    logic                  done;

    // ==================================================
    // command issue
    // ==================================================
    assign ddr_rcmd_vld_o = cmd.vld && !busy_q && !intr_q;
    assign ddr_raddr_o    = cmd.src_addr;
    assign ddr_rlen_o     = cmd.trans_len - DDR_LEN_W'(1);
    assign issue          = ddr_rcmd_vld_o && ddr_rcmd_rdy_i;
    assign cmd.pop        = issue;

    // latch placement of the running load
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            core_q   <= 1'b0;
            idx_q    <= '0;
            base_q   <= '0;
            len_m1_q <= '0;
        end else if (issue) begin
            core_q   <= cmd.core_sel;
            idx_q    <= cmd.mtx_index;
            base_q   <= cmd.mtx_offset;
            len_m1_q <= ddr_rlen_o;
        end
    end

    // ==================================================
    // data beats
    // ==================================================
    assign ddr_rdata_rdy_o = busy_q && (beat_cnt_q <= len_m1_q);
    assign accept          = ddr_rdata_vld_i && ddr_rdata_rdy_o;
    assign done            = accept && ddr_rdata_last_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q     <= 1'b0;
            beat_cnt_q <= '0;
        end else begin
            if (done) begin
                busy_q <= 1'b0;
            end else if (issue) begin
                busy_q <= 1'b1;
            end
            // counter restarts for the next load
            if (done) begin
                beat_cnt_q <= '0;
            end else if (accept) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
            end
        end
    end

    // interrupt, clear wins
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            intr_q <= 1'b0;
        end else if (intr_clr_i) begin
            intr_q <= 1'b0;
        end else if (done) begin
            intr_q <= 1'b1;
        end
    end

    assign intr_o = intr_q;

    assign beat.beat       = accept;
    assign beat.core_sel   = core_q;
    assign beat.mtx_index  = idx_q;
    assign beat.waddr_base = base_q;
    assign beat.beat_cnt   = beat_cnt_q;
    assign beat.data       = ddr_rdata_i;

endmodule

// File: source/ldmr_regfile.sv
`timescale 1ns/1ps

module ldmr_regfile import ldmr_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic [REG_ADDR_W-1:0] regmap_waddr_i,
    input  logic [REG_DATA_W-1:0] regmap_wdata_i,
    input  logic                  regmap_we_i,
    output logic                  intr_clr_o,
    ldmr_cmd_if.push              cmd
);

    logic [REG_WORD_W-1:0] word_addr;
    logic [DDR_ADDR_W-1:0] src_addr_q;
    logic [DDR_LEN_W-1:0]  trans_len_q;
    logic                  core_sel_q;
    dest_addr_u            dest_q;
    logic                  start_q;
    logic                  clr_q;

    assign word_addr = regmap_waddr_i[REG_ADDR_W-1:2];

    // ==================================================
    // configuration registers
    // ==================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            src_addr_q  <= '0;
            trans_len_q <= '0;
            core_sel_q  <= 1'b0;
            dest_q      <= '0;
        end else if (regmap_we_i) begin
            case (word_addr)
                ADDR_SRC: begin
                    // 64-byte aligned source
                    src_addr_q <= regmap_wdata_i[REG_DATA_W-1:REG_DATA_W-DDR_ADDR_W];
                end
                ADDR_LEN: begin
                    trans_len_q <= regmap_wdata_i[DDR_LEN_W-1:0];
                end
                ADDR_CORE: begin
                    core_sel_q <= regmap_wdata_i[0];
                end
                ADDR_DEST: begin
                    dest_q <= regmap_wdata_i;
                end
                default: begin
                end
            endcase
        end
    end

    // ==================================================
    // control pulses, one cycle wide
    // ==================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            start_q <= 1'b0;
            clr_q   <= 1'b0;
        end else begin
            start_q <= regmap_we_i && (word_addr == ADDR_CTRL) && regmap_wdata_i[0];
            clr_q   <= regmap_we_i && (word_addr == ADDR_CTRL) && regmap_wdata_i[1];
        end
    end

    assign intr_clr_o = clr_q;

    // command assembly
    assign cmd.vld       = start_q;
    assign cmd.core_sel  = core_sel_q;
    assign cmd.src_addr  = src_addr_q;
    assign cmd.trans_len = trans_len_q;

    // destination word decodes differently per core
    always_comb begin
        if (core_sel_q) begin
            cmd.mtx_index  = dest_q.core1.index;
            cmd.mtx_offset = dest_q.core1.offset;
        end else begin
            cmd.mtx_index  = dest_q.core0.index;
            cmd.mtx_offset = dest_q.core0.offset;
        end
    end

endmodule

// File: source/ldmr_top.sv
`timescale 1ns/1ps

module ldmr_top import ldmr_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    // register port
    input  logic [REG_ADDR_W-1:0] regmap_waddr_i,
    input  logic [REG_DATA_W-1:0] regmap_wdata_i,
    input  logic                  regmap_we_i,
    output logic                  intr_o,
    // ddr read side
    output logic [DDR_ADDR_W-1:0] ddr_raddr_o,
    output logic [DDR_LEN_W-1:0]  ddr_rlen_o,
    output logic                  ddr_rcmd_vld_o,
    input  logic                  ddr_rcmd_rdy_i,
    input  logic                  ddr_rdata_vld_i,
    input  logic                  ddr_rdata_last_i,
    input  logic [DDR_DATA_W-1:0] ddr_rdata_i,
    output logic                  ddr_rdata_rdy_o,
    // matrix register banks
    output logic                  hpu_core_sel_o,
    output logic [NUM_BANKS-1:0]  mtx_sel_o,
    output logic [DDR_DATA_W-1:0] mtx_wdata_o,
    output logic [MRA_IDX_W-1:0]  mra_windex_o,
    output logic [MTX_ADDR_W-1:0] mra_waddr_o,
    output logic                  mra_we_o,
    output logic [MRB_IDX_W-1:0]  mrb_windex_o,
    output logic [MTX_ADDR_W-1:0] mrb_waddr_o,
    output logic                  mrb_we_o,
    output logic [MRC_IDX_W-1:0]  mrc_windex_o,
    output logic [MTX_ADDR_W-1:0] mrc_waddr_o,
    output logic                  mrc_we_o,
    output logic [BR_IDX_W-1:0]   brb_windex_o,
    output logic [MTX_ADDR_W-1:0] brb_waddr_o,
    output logic                  brb_we_o,
    output logic [BR_IDX_W-1:0]   brc_windex_o,
    output logic [MTX_ADDR_W-1:0] brc_waddr_o,
    output logic                  brc_we_o
);

    logic intr_clr;

    ldmr_cmd_if  cmd_push ();
    ldmr_cmd_if  cmd_head ();
    ldmr_beat_if beat_bus ();

    ldmr_regfile u_regfile (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .regmap_waddr_i (regmap_waddr_i),
        .regmap_wdata_i (regmap_wdata_i),
        .regmap_we_i    (regmap_we_i),
        .intr_clr_o     (intr_clr),
        .cmd            (cmd_push.push)
    );

    ldmr_cmd_fifo u_cmd_fifo (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .wr    (cmd_push.fifo_in),
        .rd    (cmd_head.fifo_out)
    );

    ldmr_read_ctrl u_read_ctrl (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .intr_clr_i       (intr_clr),
        .ddr_rcmd_rdy_i   (ddr_rcmd_rdy_i),
        .ddr_rdata_vld_i  (ddr_rdata_vld_i),
        .ddr_rdata_last_i (ddr_rdata_last_i),
        .ddr_rdata_i      (ddr_rdata_i),
        .ddr_raddr_o      (ddr_raddr_o),
        .ddr_rlen_o       (ddr_rlen_o),
        .ddr_rcmd_vld_o   (ddr_rcmd_vld_o),
        .ddr_rdata_rdy_o  (ddr_rdata_rdy_o),
        .intr_o           (intr_o),
        .cmd              (cmd_head.take),
        .beat             (beat_bus.src)
    );

    ldmr_bank_writer u_bank_writer (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .beat           (beat_bus.dst),
        .hpu_core_sel_o (hpu_core_sel_o),
        .mtx_sel_o      (mtx_sel_o),
        .mtx_wdata_o    (mtx_wdata_o),
        .mra_windex_o   (mra_windex_o),
        .mra_waddr_o    (mra_waddr_o),
        .mra_we_o       (mra_we_o),
        .mrb_windex_o   (mrb_windex_o),
        .mrb_waddr_o    (mrb_waddr_o),
        .mrb_we_o       (mrb_we_o),
        .mrc_windex_o   (mrc_windex_o),
        .mrc_waddr_o    (mrc_waddr_o),
        .mrc_we_o       (mrc_we_o),
        .brb_windex_o   (brb_windex_o),
        .brb_waddr_o    (brb_waddr_o),
        .brb_we_o       (brb_we_o),
        .brc_windex_o   (brc_windex_o),
        .brc_waddr_o    (brc_waddr_o),
        .brc_we_o       (brc_we_o)
    );

endmodule

// File: verif/ldmr_tb.sv
`timescale 1ns/1ps

module ldmr_tb import ldmr_pkg::*; ();

    typedef struct packed {
        logic [DDR_ADDR_W-1:0] src;
        logic [DDR_LEN_W-1:0]  len;
        logic                  core;
        logic [MTX_IDX_W-1:0]  idx;
        logic [MTX_ADDR_W-1:0] off;
    } load_t;

    typedef struct packed {
        logic                  core;
        logic [4:0]            sel;
        logic [2:0]            lidx;
        logic [MTX_ADDR_W-1:0] addr;
        logic [DDR_DATA_W-1:0] data;
    } wr_t;

    logic clk_i, rst_i, regmap_we_i, intr_o, hpu_core_sel_o;
    logic [REG_ADDR_W-1:0] regmap_waddr_i;
    logic [REG_DATA_W-1:0] regmap_wdata_i;
    logic [DDR_ADDR_W-1:0] ddr_raddr_o;
    logic [DDR_LEN_W-1:0]  ddr_rlen_o;
    logic ddr_rcmd_vld_o, ddr_rcmd_rdy_i, ddr_rdata_vld_i, ddr_rdata_last_i, ddr_rdata_rdy_o;
    logic [DDR_DATA_W-1:0] ddr_rdata_i, mtx_wdata_o;
    logic [4:0] mtx_sel_o;
    logic [2:0] mra_windex_o, mrb_windex_o;
    logic mrc_windex_o, brb_windex_o, brc_windex_o;
    logic [8:0] mra_waddr_o, mrb_waddr_o, mrc_waddr_o, brb_waddr_o, brc_waddr_o;
    logic mra_we_o, mrb_we_o, mrc_we_o, brb_we_o, brc_we_o;

    logic [4:0]  got_we;
    logic [8:0]  got_idx;
    logic [44:0] got_addr;
    load_t cmd_q[$];
    wr_t   wr_q[$];
    load_t cur;
    logic  active;
    logic  started;
    int    beat_cnt;
    int    mismatch_errors;
    int    other_errors;

    ldmr_top DUT (.*);

    // banks packed with mra in the low bits as in the expected vectors
    assign got_we   = {brc_we_o, brb_we_o, mrc_we_o, mrb_we_o, mra_we_o};
    assign got_idx  = {brc_windex_o, brb_windex_o, mrc_windex_o, mrb_windex_o, mra_windex_o};
    assign got_addr = {brc_waddr_o, brb_waddr_o, mrc_waddr_o, mrb_waddr_o, mra_waddr_o};

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic check_value(input string name, input logic [511:0] got,
                               input logic [511:0] exp);
        assert (got === exp) else begin
            mismatch_errors++;
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // ==================================================
    // reference for bank writes
    // ==================================================
    function automatic wr_t expect_write(input load_t ld, input int cnt,
                                         input logic [511:0] data);
        wr_t w;
        int run;
        int idx;
        run = ld.off + cnt;
        idx = ld.idx + run / 512;
        w.core = ld.core;
        w.addr = 9'(run % 512);
        w.data = data;
        if (idx < 8) begin
            w.sel  = 5'b00001;
            w.lidx = 3'(idx);
        end else if (idx < 16) begin
            w.sel  = 5'b00010;
            w.lidx = 3'(idx - 8);
        end else if (idx < 18) begin
            w.sel  = 5'b00100;
            w.lidx = 3'(idx - 16);
        end else begin
            w.sel  = (idx == 18) ? 5'b01000 : 5'b10000;
            w.lidx = 3'd0;
        end
        return w;
    endfunction

    function automatic logic [8:0] index_vec(input wr_t w);
        logic [8:0] v;
        v = '0;
        if (w.sel[0]) v[2:0] = w.lidx;
        if (w.sel[1]) v[5:3] = w.lidx;
        if (w.sel[2]) v[6] = w.lidx[0];
        return v;
    endfunction

    function automatic logic [44:0] addr_vec(input wr_t w);
        logic [44:0] v;
        v = '0;
        for (int b = 0; b < 5; b++) begin
            if (w.sel[b]) v[b*9 +: 9] = w.addr;
        end
        return v;
    endfunction

    always @(posedge clk_i) begin : scoreboard
        wr_t w;
        load_t ld;
        if (!rst_i) begin
            // write from the beat accepted one cycle earlier
            if (wr_q.size() > 0) begin
                w = wr_q.pop_front();
                check_value("bank we", got_we, w.sel);
                check_value("mtx_sel_o", mtx_sel_o, w.sel);
                check_value("hpu_core_sel_o", hpu_core_sel_o, w.core);
                check_value("bank windex", got_idx, index_vec(w));
                check_value("bank waddr", got_addr, addr_vec(w));
                check_value("mtx_wdata_o", mtx_wdata_o, w.data);
            end else begin
                check_value("bank we", got_we, 5'b0);
            end
            // data ready only while a load is running
            check_value("ddr_rdata_rdy_o", ddr_rdata_rdy_o, active);
            if (ddr_rcmd_vld_o && ddr_rcmd_rdy_i) begin
                if (cmd_q.size() == 0) begin
                    other_errors++;
                    $display("read command issued at %0t with no load queued", $time);
                end else begin
                    ld = cmd_q.pop_front();
                    check_value("ddr_raddr_o", ddr_raddr_o, ld.src);
                    check_value("ddr_rlen_o", ddr_rlen_o, 16'(ld.len - 1));
                    cur      = ld;
                    active   = 1'b1;
                    beat_cnt = 0;
                end
            end
            if (ddr_rdata_vld_i && ddr_rdata_rdy_o) begin
                wr_q.push_back(expect_write(cur, beat_cnt, ddr_rdata_i));
                beat_cnt++;
                if (ddr_rdata_last_i) active = 1'b0;
            end
        end
    end

    // ==================================================
    // protocol checks
    // ==================================================
    a_idle: assert property (@(posedge clk_i) disable iff (rst_i)
        !started |-> (got_we == 5'b0 && !ddr_rcmd_vld_o && !ddr_rdata_rdy_o && !intr_o))
    else begin
        mismatch_errors++;
        $display("MISMATCH at %0t: we cmd_vld rdata_rdy intr got %b %b %b %b expected 0",
                 $time, $sampled(got_we), $sampled(ddr_rcmd_vld_o),
                 $sampled(ddr_rdata_rdy_o), $sampled(intr_o));
    end

    a_write_follows_beat: assert property (@(posedge clk_i) disable iff (rst_i)
        (ddr_rdata_vld_i && ddr_rdata_rdy_o) |=> $onehot(got_we))
    else begin
        mismatch_errors++;
        $display("MISMATCH at %0t: bank we got %b expected one-hot", $time, $sampled(got_we));
    end

    a_intr_blocks: assert property (@(posedge clk_i) disable iff (rst_i)
        intr_o |-> !ddr_rcmd_vld_o)
    else begin
        mismatch_errors++;
        $display("MISMATCH at %0t: ddr_rcmd_vld_o got 1 expected 0 while intr_o", $time);
    end

    a_intr_sets: assert property (@(posedge clk_i) disable iff (rst_i)
        (ddr_rdata_vld_i && ddr_rdata_rdy_o && ddr_rdata_last_i) |=> intr_o)
    else begin
        mismatch_errors++;
        $display("MISMATCH at %0t: intr_o got %b expected 1", $time, $sampled(intr_o));
    end

    a_intr_clears: assert property (@(posedge clk_i) disable iff (rst_i)
        (regmap_we_i && regmap_waddr_i == 8'h00 && regmap_wdata_i[1]) |=> ##1 !intr_o)
    else begin
        mismatch_errors++;
        $display("MISMATCH at %0t: intr_o got %b expected 0", $time, $sampled(intr_o));
    end

    // ddr model with random valid gaps and command ready
    initial begin : ddr_responder
        int beats_left;
        logic issue_s;
        logic accept_s;
        logic [15:0] rlen_s;
        void'($urandom(32'h945c_64ca));
        ddr_rcmd_rdy_i   = 1'b0;
        ddr_rdata_vld_i  = 1'b0;
        ddr_rdata_last_i = 1'b0;
        ddr_rdata_i      = '0;
        beats_left       = 0;
        forever begin
            @(posedge clk_i);
            issue_s  = ddr_rcmd_vld_o && ddr_rcmd_rdy_i;
            accept_s = ddr_rdata_vld_i && ddr_rdata_rdy_o;
            rlen_s   = ddr_rlen_o;
            #1;
            if (issue_s === 1'b1) beats_left = rlen_s + 1;
            if (accept_s === 1'b1) begin
                beats_left--;
                ddr_rdata_vld_i  = 1'b0;
                ddr_rdata_last_i = 1'b0;
            end
            ddr_rcmd_rdy_i = ($urandom % 3) != 0;
            if (beats_left > 0 && !ddr_rdata_vld_i && ($urandom % 4) != 0) begin
                ddr_rdata_vld_i  = 1'b1;
                ddr_rdata_last_i = (beats_left == 1);
                for (int i = 0; i < 16; i++) ddr_rdata_i[i*32 +: 32] = $urandom;
            end
        end
    end

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic reg_write(input logic [5:0] word, input logic [31:0] data);
        regmap_waddr_i = {word, 2'b00};
        regmap_wdata_i = data;
        regmap_we_i    = 1'b1;
        idle(1);
        regmap_we_i    = 1'b0;
    endtask

    task automatic queue_load(input logic [25:0] src, input logic [15:0] len,
                              input logic core, input logic [4:0] idx, input logic [8:0] off);
        load_t ld;
        logic [31:0] dest;
        // other core's field holds a decoy
        if (core) dest = {2'b00, idx, off, 2'b00, ~idx, ~off};
        else dest = {2'b00, ~idx, ~off, 2'b00, idx, off};
        ld.src  = src;
        ld.len  = len;
        ld.core = core;
        ld.idx  = idx;
        ld.off  = off;
        cmd_q.push_back(ld);
        reg_write(ADDR_SRC, {src, 6'b0});
        reg_write(ADDR_LEN, {16'h0, len});
        reg_write(ADDR_CORE, {31'h0, core});
        reg_write(ADDR_DEST, dest);
        started = 1'b1;
        reg_write(ADDR_CTRL, 32'h1);
    endtask

    task automatic wait_intr(input int limit);
        int cycles;
        cycles = 0;
        while (intr_o !== 1'b1 && cycles < limit) begin
            idle(1);
            cycles++;
        end
        if (intr_o !== 1'b1) begin
            other_errors++;
            $display("timeout at %0t: no interrupt within %0d cycles", $time, limit);
        end
    endtask

    initial begin : stimulus
        rst_i = 1'b1;
        regmap_waddr_i = '0;
        regmap_wdata_i = '0;
        regmap_we_i = 1'b0;
        started = 1'b0;
        active = 1'b0;
        beat_cnt = 0;
        mismatch_errors = 0;
        other_errors = 0;
        repeat (16) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        idle(8);
        // every index under both cores
        for (int c = 0; c < 2; c++) begin
            for (int i = 0; i < 20; i++) begin
                queue_load(26'(32'h100 + i + c * 64), 16'(2 + i % 3), c[0], 5'(i),
                           9'((i * 37 + c * 100) % 512));
                wait_intr(500);
                reg_write(ADDR_CTRL, 32'h2);
            end
        end
        // runs past 511 into the next register
        queue_load(26'h2000, 16'd4, 1'b0, 5'd7, 9'd510);
        wait_intr(500);
        reg_write(ADDR_CTRL, 32'h2);
        queue_load(26'h2100, 16'd3, 1'b1, 5'd17, 9'd511);
        wait_intr(500);
        reg_write(ADDR_CTRL, 32'h2);
        queue_load(26'h2200, 16'd6, 1'b0, 5'd15, 9'd509);
        wait_intr(500);
        reg_write(ADDR_CTRL, 32'h2);
        // queued back to back and each held off by the interrupt
        queue_load(26'h3a5_5a5, 16'd5, 1'b1, 5'd2, 9'd40);
        queue_load(26'h012_345, 16'd3, 1'b0, 5'd12, 9'd300);
        queue_load(26'h3ff_fff, 16'd7, 1'b1, 5'd19, 9'd7);
        repeat (3) begin
            wait_intr(500);
            idle(6);
            reg_write(ADDR_CTRL, 32'h2);
        end
        idle(10);
        if (cmd_q.size() != 0 || wr_q.size() != 0 || active) begin
            other_errors++;
            $display("run ended with %0d loads and %0d writes outstanding",
                     cmd_q.size(), wr_q.size());
        end
        $display("error counts: %0d mismatches, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
